/* common/xbar_pkg.sv */
`default_nettype none

package xbar_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;

    // Table position is the target index
    typedef struct packed {
        addr_t start_addr;
        addr_t end_addr;   // Exclusive
    } addr_rule_t;

    typedef logic [0:0] tgt_idx_t; // Two targets

    // Response error codes
    localparam logic RSP_OK  = 1'b0;
    localparam logic RSP_ERR = 1'b1;

endpackage

`default_nettype wire

/* logic/axil_pause.sv */
`default_nettype none

module axil_pause #(
    parameter int MAX_TRANS = 7
) (
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic            pause_req_i,

    input  logic            req_valid_i,
    output logic            req_ready_o,
    input  xbar_pkg::addr_t req_addr_i,
    input  logic            req_write_i,
    input  xbar_pkg::data_t req_wdata_i,
    input  xbar_pkg::strb_t req_strb_i,

    output logic            fwd_valid_o,
    input  logic            fwd_ready_i,
    output xbar_pkg::addr_t fwd_addr_o,
    output logic            fwd_write_o,
    output xbar_pkg::data_t fwd_wdata_o,
    output xbar_pkg::strb_t fwd_strb_o,

    output logic            rsp_valid_o,
    input  logic            rsp_ready_i,
    output xbar_pkg::data_t rsp_rdata_o,
    output logic            rsp_err_o,

    input  logic            ret_valid_i,
    output logic            ret_ready_o,
    input  xbar_pkg::data_t ret_rdata_i,
    input  logic            ret_err_i,

    output logic            quiet_o
);
    import xbar_pkg::*;

    localparam int CW = $clog2(MAX_TRANS + 1);

    logic [CW-1:0] cnt_q;
    logic          hold_q;  // Request already visible downstream
    logic          block;
    logic          fwd_hs;
    logic          ret_hs;

    // A request already offered is never withdrawn
    assign block = (pause_req_i || cnt_q == CW'(MAX_TRANS)) && !hold_q;

    assign fwd_valid_o = req_valid_i && !block;
    assign req_ready_o = fwd_ready_i && !block;
    assign fwd_addr_o  = req_addr_i;
    assign fwd_write_o = req_write_i;
    assign fwd_wdata_o = req_wdata_i;
    assign fwd_strb_o  = req_strb_i;

    assign rsp_valid_o = ret_valid_i;
    assign ret_ready_o = rsp_ready_i;
    assign rsp_rdata_o = ret_rdata_i;
    assign rsp_err_o   = ret_err_i;

    assign fwd_hs = fwd_valid_o && fwd_ready_i;
    assign ret_hs = ret_valid_i && ret_ready_o;

    assign quiet_o = pause_req_i && cnt_q == '0 && !fwd_valid_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cnt_q  <= '0;
            hold_q <= 1'b0;
        end else begin
            hold_q <= fwd_valid_o && !fwd_ready_i;
            case ({fwd_hs, ret_hs})
                2'b10:   cnt_q <= cnt_q + CW'(1);
                2'b01:   cnt_q <= cnt_q - CW'(1);
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    // Router must not return more than it was given
    assert property (@(posedge clk_i) disable iff (reset_i)
        ret_hs |-> cnt_q != '0);

    // An offered request stays up through a pause
    assert property (@(posedge clk_i) disable iff (reset_i)
        fwd_valid_o && !fwd_ready_i |=> fwd_valid_o);

endmodule

`default_nettype wire

/* xbar/addr_decode.sv */
`default_nettype none

module addr_decode #(
    parameter int NO_TGTS = 2
) (
    input  xbar_pkg::addr_t                    addr_i,
    input  xbar_pkg::addr_rule_t [NO_TGTS-1:0] addr_map_i,
    output logic                               hit_o,
    output xbar_pkg::tgt_idx_t                 idx_o
);
    import xbar_pkg::*;

    logic [NO_TGTS-1:0] match;

    always_comb begin
        for (int t = 0; t < NO_TGTS; t++) begin
            match[t] = (addr_i >= addr_map_i[t].start_addr) &&
                       (addr_i < addr_map_i[t].end_addr);
        end
    end

    // Lowest index wins
    always_comb begin
        idx_o = '0;
        for (int t = NO_TGTS - 1; t >= 0; t--) begin
            if (match[t]) begin
                idx_o = tgt_idx_t'(t);
            end
        end
    end

    assign hit_o = |match;

    always_comb begin
        logic ov;
        ov = 1'b0;
        for (int a = 0; a < NO_TGTS; a++) begin
            for (int b = a + 1; b < NO_TGTS; b++) begin
                ov = addr_map_i[a].start_addr < addr_map_i[b].end_addr &&
                     addr_map_i[b].start_addr < addr_map_i[a].end_addr;
                assert (ov !== 1'b1)
                    else $error("addr rules %0d and %0d overlap", a, b);
            end
        end
    end

endmodule

`default_nettype wire

/* xbar/xbar_router.sv */
`default_nettype none

module xbar_router #(
    parameter int NO_TGTS = 2
) (
    input  logic                               clk_i,
    input  logic                               reset_i,
    input  logic                               pause_req_i,

    input  logic                               fwd_valid_0_i,
    output logic                               fwd_ready_0_o,
    input  xbar_pkg::addr_t                    fwd_addr_0_i,
    input  logic                               fwd_write_0_i,
    input  xbar_pkg::data_t                    fwd_wdata_0_i,
    input  xbar_pkg::strb_t                    fwd_strb_0_i,
    output logic                               ret_valid_0_o,
    input  logic                               ret_ready_0_i,
    output xbar_pkg::data_t                    ret_rdata_0_o,
    output logic                               ret_err_0_o,

    input  logic                               fwd_valid_1_i,
    output logic                               fwd_ready_1_o,
    input  xbar_pkg::addr_t                    fwd_addr_1_i,
    input  logic                               fwd_write_1_i,
    input  xbar_pkg::data_t                    fwd_wdata_1_i,
    input  xbar_pkg::strb_t                    fwd_strb_1_i,
    output logic                               ret_valid_1_o,
    input  logic                               ret_ready_1_i,
    output xbar_pkg::data_t                    ret_rdata_1_o,
    output logic                               ret_err_1_o,

    input  logic                               quiet_0_i,
    input  logic                               quiet_1_i,
    input  xbar_pkg::addr_rule_t [NO_TGTS-1:0] addr_map_i,

    output logic [NO_TGTS-1:0]                 tgt_req_valid_o,
    input  logic [NO_TGTS-1:0]                 tgt_req_ready_i,
    output xbar_pkg::addr_t [NO_TGTS-1:0]      tgt_req_addr_o,
    output logic [NO_TGTS-1:0]                 tgt_req_write_o,
    output xbar_pkg::data_t [NO_TGTS-1:0]      tgt_req_wdata_o,
    output xbar_pkg::strb_t [NO_TGTS-1:0]      tgt_req_strb_o,
    input  logic [NO_TGTS-1:0]                 tgt_rsp_valid_i,
    output logic [NO_TGTS-1:0]                 tgt_rsp_ready_o,
    input  xbar_pkg::data_t [NO_TGTS-1:0]      tgt_rsp_rdata_i,
    input  logic [NO_TGTS-1:0]                 tgt_rsp_err_i,

    output logic                               pause_ack_o
);
    import xbar_pkg::*;

    logic     [1:0] in_valid, in_ready, in_write, in_hit;
    addr_t    [1:0] in_addr;
    data_t    [1:0] in_wdata;
    strb_t    [1:0] in_strb;
    tgt_idx_t [1:0] in_idx;
    logic     [1:0] out_ready;

    logic [NO_TGTS-1:0][1:0] want, gnt;
    logic [NO_TGTS-1:0]      owned_q, owner_q, rr_q;

    logic     [1:0] rsp_valid_q, rsp_err_q, err_valid_q;
    data_t    [1:0] rsp_rdata_q;
    tgt_idx_t [1:0] rsp_tgt_q;  // Target that filled the slot
    logic     [1:0] miss_acc, rsp_pop, err_pop;

    assign in_valid  = {fwd_valid_1_i, fwd_valid_0_i};
    assign in_addr   = {fwd_addr_1_i, fwd_addr_0_i};
    assign in_write  = {fwd_write_1_i, fwd_write_0_i};
    assign in_wdata  = {fwd_wdata_1_i, fwd_wdata_0_i};
    assign in_strb   = {fwd_strb_1_i, fwd_strb_0_i};
    assign out_ready = {ret_ready_1_i, ret_ready_0_i};

    assign fwd_ready_0_o = in_ready[0];
    assign fwd_ready_1_o = in_ready[1];

    for (genvar i = 0; i < 2; i++) begin : g_dec
        addr_decode #(
            .NO_TGTS (NO_TGTS)
        ) u_addr_decode (
            .addr_i     (in_addr[i]),
            .addr_map_i (addr_map_i),
            .hit_o      (in_hit[i]),
            .idx_o      (in_idx[i])
        );
    end

    // Round-robin per target, free targets only
    always_comb begin
        for (int t = 0; t < NO_TGTS; t++) begin
            for (int i = 0; i < 2; i++) begin
                want[t][i] = in_valid[i] && in_hit[i] && in_idx[i] == tgt_idx_t'(t);
            end
            gnt[t] = '0;
            if (!owned_q[t]) begin
                if (want[t] == 2'b11) begin
                    gnt[t][rr_q[t]] = 1'b1;
                end else begin
                    gnt[t] = want[t];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            miss_acc[i] = in_valid[i] && !in_hit[i] && !err_valid_q[i];
            in_ready[i] = miss_acc[i];
            for (int t = 0; t < NO_TGTS; t++) begin
                in_ready[i] = in_ready[i] | gnt[t][i];
            end
            rsp_pop[i] = rsp_valid_q[i] && out_ready[i];
            err_pop[i] = !rsp_valid_q[i] && err_valid_q[i] && out_ready[i];
        end
    end

    // One response per initiator slot, lower target first
    always_comb begin
        logic [1:0] busy;
        busy = rsp_valid_q;
        for (int t = 0; t < NO_TGTS; t++) begin
            tgt_rsp_ready_o[t] = owned_q[t] && !busy[owner_q[t]];
            busy[owner_q[t]] = busy[owner_q[t]] | (tgt_rsp_ready_o[t] & tgt_rsp_valid_i[t]);
        end
    end

    assign ret_valid_0_o = rsp_valid_q[0] || err_valid_q[0];
    assign ret_valid_1_o = rsp_valid_q[1] || err_valid_q[1];
    assign ret_rdata_0_o = rsp_valid_q[0] ? rsp_rdata_q[0] : '0;
    assign ret_rdata_1_o = rsp_valid_q[1] ? rsp_rdata_q[1] : '0;
    assign ret_err_0_o   = rsp_valid_q[0] ? rsp_err_q[0] : (err_valid_q[0] ? RSP_ERR : RSP_OK);
    assign ret_err_1_o   = rsp_valid_q[1] ? rsp_err_q[1] : (err_valid_q[1] ? RSP_ERR : RSP_OK);

    assign pause_ack_o = pause_req_i && quiet_0_i && quiet_1_i && !(|owned_q) && !(|err_valid_q);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            owned_q         <= '0;
            owner_q         <= '0;
            rr_q            <= '0;
            tgt_req_valid_o <= '0;
            rsp_valid_q     <= '0;
            err_valid_q     <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (rsp_pop[i]) begin
                    rsp_valid_q[i] <= 1'b0;
                end
                if (miss_acc[i]) begin
                    err_valid_q[i] <= 1'b1;
                end else if (err_pop[i]) begin
                    err_valid_q[i] <= 1'b0;
                end
            end
            for (int t = 0; t < NO_TGTS; t++) begin
                if (tgt_req_valid_o[t] && tgt_req_ready_i[t]) begin
                    tgt_req_valid_o[t] <= 1'b0;
                end
                if (tgt_rsp_valid_i[t] && tgt_rsp_ready_o[t]) begin
                    rsp_valid_q[owner_q[t]] <= 1'b1;
                end
                if (|gnt[t]) begin
                    owned_q[t]         <= 1'b1;
                    owner_q[t]         <= gnt[t][1];
                    rr_q[t]            <= !rr_q[t];
                    tgt_req_valid_o[t] <= 1'b1;
                end else if (rsp_pop[owner_q[t]] &&
                             rsp_tgt_q[owner_q[t]] == tgt_idx_t'(t)) begin
                    owned_q[t] <= 1'b0;  // Released once delivered
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int t = 0; t < NO_TGTS; t++) begin
            if (|gnt[t]) begin
                tgt_req_addr_o[t]  <= in_addr[gnt[t][1]];
                tgt_req_write_o[t] <= in_write[gnt[t][1]];
                tgt_req_wdata_o[t] <= in_wdata[gnt[t][1]];
                tgt_req_strb_o[t]  <= in_strb[gnt[t][1]];
            end
            if (tgt_rsp_valid_i[t] && tgt_rsp_ready_o[t]) begin
                rsp_rdata_q[owner_q[t]] <= tgt_rsp_rdata_i[t];
                rsp_err_q[owner_q[t]]   <= tgt_rsp_err_i[t];
                rsp_tgt_q[owner_q[t]]   <= tgt_idx_t'(t);
            end
        end
    end

    for (genvar t = 0; t < NO_TGTS; t++) begin : g_chk
        // Targets answer only requests they have taken
        assert property (@(posedge clk_i) disable iff (reset_i)
            tgt_rsp_valid_i[t] |-> owned_q[t] && !tgt_req_valid_o[t]);
    end

endmodule

`default_nettype wire

/* xbar/axil_xbar.sv */
`default_nettype none

module axil_xbar #(
    parameter int NO_TGTS   = 2,
    parameter int MAX_TRANS = 7
) (
    input  logic                               clk_i,
    input  logic                               reset_i,

    input  logic                               req_valid_0_i,
    output logic                               req_ready_0_o,
    input  xbar_pkg::addr_t                    req_addr_0_i,
    input  logic                               req_write_0_i,
    input  xbar_pkg::data_t                    req_wdata_0_i,
    input  xbar_pkg::strb_t                    req_strb_0_i,
    output logic                               rsp_valid_0_o,
    input  logic                               rsp_ready_0_i,
    output xbar_pkg::data_t                    rsp_rdata_0_o,
    output logic                               rsp_err_0_o,

    input  logic                               req_valid_1_i,
    output logic                               req_ready_1_o,
    input  xbar_pkg::addr_t                    req_addr_1_i,
    input  logic                               req_write_1_i,
    input  xbar_pkg::data_t                    req_wdata_1_i,
    input  xbar_pkg::strb_t                    req_strb_1_i,
    output logic                               rsp_valid_1_o,
    input  logic                               rsp_ready_1_i,
    output xbar_pkg::data_t                    rsp_rdata_1_o,
    output logic                               rsp_err_1_o,

    output logic [NO_TGTS-1:0]                 tgt_req_valid_o,
    input  logic [NO_TGTS-1:0]                 tgt_req_ready_i,
    output xbar_pkg::addr_t [NO_TGTS-1:0]      tgt_req_addr_o,
    output logic [NO_TGTS-1:0]                 tgt_req_write_o,
    output xbar_pkg::data_t [NO_TGTS-1:0]      tgt_req_wdata_o,
    output xbar_pkg::strb_t [NO_TGTS-1:0]      tgt_req_strb_o,
    input  logic [NO_TGTS-1:0]                 tgt_rsp_valid_i,
    output logic [NO_TGTS-1:0]                 tgt_rsp_ready_o,
    input  xbar_pkg::data_t [NO_TGTS-1:0]      tgt_rsp_rdata_i,
    input  logic [NO_TGTS-1:0]                 tgt_rsp_err_i,

    input  logic                               pause_req_i,
    output logic                               pause_ack_o,
    input  xbar_pkg::addr_rule_t [NO_TGTS-1:0] addr_map_i
);
    import xbar_pkg::*;

    logic  fwd_valid_0, fwd_ready_0, fwd_write_0, ret_valid_0, ret_ready_0, ret_err_0, quiet_0;
    logic  fwd_valid_1, fwd_ready_1, fwd_write_1, ret_valid_1, ret_ready_1, ret_err_1, quiet_1;
    addr_t fwd_addr_0, fwd_addr_1;
    data_t fwd_wdata_0, fwd_wdata_1, ret_rdata_0, ret_rdata_1;
    strb_t fwd_strb_0, fwd_strb_1;

    axil_pause #(
        .MAX_TRANS (MAX_TRANS)
    ) u_pause_0 (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .pause_req_i (pause_req_i),
        .req_valid_i (req_valid_0_i), .req_ready_o (req_ready_0_o),
        .req_addr_i  (req_addr_0_i),  .req_write_i (req_write_0_i),
        .req_wdata_i (req_wdata_0_i), .req_strb_i  (req_strb_0_i),
        .fwd_valid_o (fwd_valid_0),   .fwd_ready_i (fwd_ready_0),
        .fwd_addr_o  (fwd_addr_0),    .fwd_write_o (fwd_write_0),
        .fwd_wdata_o (fwd_wdata_0),   .fwd_strb_o  (fwd_strb_0),
        .rsp_valid_o (rsp_valid_0_o), .rsp_ready_i (rsp_ready_0_i),
        .rsp_rdata_o (rsp_rdata_0_o), .rsp_err_o   (rsp_err_0_o),
        .ret_valid_i (ret_valid_0),   .ret_ready_o (ret_ready_0),
        .ret_rdata_i (ret_rdata_0),   .ret_err_i   (ret_err_0),
        .quiet_o     (quiet_0)
    );

    axil_pause #(
        .MAX_TRANS (MAX_TRANS)
    ) u_pause_1 (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .pause_req_i (pause_req_i),
        .req_valid_i (req_valid_1_i), .req_ready_o (req_ready_1_o),
        .req_addr_i  (req_addr_1_i),  .req_write_i (req_write_1_i),
        .req_wdata_i (req_wdata_1_i), .req_strb_i  (req_strb_1_i),
        .fwd_valid_o (fwd_valid_1),   .fwd_ready_i (fwd_ready_1),
        .fwd_addr_o  (fwd_addr_1),    .fwd_write_o (fwd_write_1),
        .fwd_wdata_o (fwd_wdata_1),   .fwd_strb_o  (fwd_strb_1),
        .rsp_valid_o (rsp_valid_1_o), .rsp_ready_i (rsp_ready_1_i),
        .rsp_rdata_o (rsp_rdata_1_o), .rsp_err_o   (rsp_err_1_o),
        .ret_valid_i (ret_valid_1),   .ret_ready_o (ret_ready_1),
        .ret_rdata_i (ret_rdata_1),   .ret_err_i   (ret_err_1),
        .quiet_o     (quiet_1)
    );

    xbar_router #(
        .NO_TGTS (NO_TGTS)
    ) u_router (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .pause_req_i     (pause_req_i),
        .fwd_valid_0_i   (fwd_valid_0), .fwd_ready_0_o (fwd_ready_0),
        .fwd_addr_0_i    (fwd_addr_0),  .fwd_write_0_i (fwd_write_0),
        .fwd_wdata_0_i   (fwd_wdata_0), .fwd_strb_0_i  (fwd_strb_0),
        .ret_valid_0_o   (ret_valid_0), .ret_ready_0_i (ret_ready_0),
        .ret_rdata_0_o   (ret_rdata_0), .ret_err_0_o   (ret_err_0),
        .fwd_valid_1_i   (fwd_valid_1), .fwd_ready_1_o (fwd_ready_1),
        .fwd_addr_1_i    (fwd_addr_1),  .fwd_write_1_i (fwd_write_1),
        .fwd_wdata_1_i   (fwd_wdata_1), .fwd_strb_1_i  (fwd_strb_1),
        .ret_valid_1_o   (ret_valid_1), .ret_ready_1_i (ret_ready_1),
        .ret_rdata_1_o   (ret_rdata_1), .ret_err_1_o   (ret_err_1),
        .quiet_0_i       (quiet_0),
        .quiet_1_i       (quiet_1),
        .addr_map_i      (addr_map_i),
        .tgt_req_valid_o (tgt_req_valid_o),
        .tgt_req_ready_i (tgt_req_ready_i),
        .tgt_req_addr_o  (tgt_req_addr_o),
        .tgt_req_write_o (tgt_req_write_o),
        .tgt_req_wdata_o (tgt_req_wdata_o),
        .tgt_req_strb_o  (tgt_req_strb_o),
        .tgt_rsp_valid_i (tgt_rsp_valid_i),
        .tgt_rsp_ready_o (tgt_rsp_ready_o),
        .tgt_rsp_rdata_i (tgt_rsp_rdata_i),
        .tgt_rsp_err_i   (tgt_rsp_err_i),
        .pause_ack_o     (pause_ack_o)
    );

endmodule

`default_nettype wire

/* dv/tb_target_model.sv */
`default_nettype none

module tb_target_model (
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic [3:0]      delay_i,      // Cycles of ready low per request

    input  logic            req_valid_i,
    output logic            req_ready_o,
    input  xbar_pkg::addr_t req_addr_i,
    input  logic            req_write_i,
    input  xbar_pkg::data_t req_wdata_i,
    input  xbar_pkg::strb_t req_strb_i,

    output logic            rsp_valid_o,
    input  logic            rsp_ready_i,
    output xbar_pkg::data_t rsp_rdata_o,
    output logic            rsp_err_o,

    output logic [31:0]     req_cnt_o     // Requests taken since reset
);
    import xbar_pkg::*;

    data_t      mem [1024];
    logic [3:0] wait_q;
    logic [9:0] idx;

    assign idx = req_addr_i[11:2];  // Word inside the 4 KiB window

    always @(posedge clk_i) begin
        if (reset_i) begin
            req_ready_o <= 1'b0;
            rsp_valid_o <= 1'b0;
            rsp_rdata_o <= '0;
            rsp_err_o   <= 1'b0;
            wait_q      <= '0;
            req_cnt_o   <= '0;
            for (int i = 0; i < 1024; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (rsp_valid_o && rsp_ready_i) begin
                rsp_valid_o <= 1'b0;
            end
            if (req_valid_i && req_ready_o) begin
                req_ready_o <= 1'b0;
                req_cnt_o   <= req_cnt_o + 32'd1;
                rsp_valid_o <= 1'b1;
                rsp_err_o   <= 1'b0;
                if (req_write_i) begin
                    rsp_rdata_o <= '0;
                    for (int b = 0; b < STRB_WIDTH; b++) begin
                        if (req_strb_i[b]) begin
                            mem[idx][8*b +: 8] <= req_wdata_i[8*b +: 8];
                        end
                    end
                end else begin
                    rsp_rdata_o <= mem[idx];
                end
            end else if (req_valid_i && !rsp_valid_o) begin
                if (wait_q >= delay_i) begin
                    req_ready_o <= 1'b1;
                    wait_q      <= '0;
                end else begin
                    wait_q <= wait_q + 4'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* dv/tb_axil_xbar.sv */
`default_nettype none

module tb_axil_xbar;
    import xbar_pkg::*;

    localparam int TEST_LEN = 12 + 2 + 16 + 3 + 2;  // Transactions per test, summed

    logic   clk;
    logic   reset;
    logic   pause_req;
    wire    pause_ack;
    integer seed;
    int     errors;
    int     checks;
    int     tests;

    logic  [1:0] req_valid, req_write, rsp_ready;
    addr_t       req_addr [2];
    data_t       req_wdata [2];
    strb_t       req_strb [2];
    wire   [1:0] req_ready, rsp_valid, rsp_err;
    wire data_t  rsp_rdata [2];

    addr_rule_t [1:0] addr_map;
    logic [1:0][3:0]  tgt_delay;

    wire [1:0]        tgt_req_valid, tgt_req_ready, tgt_req_write;
    wire [1:0]        tgt_rsp_valid, tgt_rsp_ready, tgt_rsp_err;
    wire addr_t [1:0] tgt_req_addr;
    wire data_t [1:0] tgt_req_wdata, tgt_rsp_rdata;
    wire strb_t [1:0] tgt_req_strb;
    wire [1:0][31:0]  tgt_req_cnt;

    data_t sb [addr_t];  // Expected memory image

    always #20 clk = ~clk;

    axil_xbar #(
        .NO_TGTS   (2),
        .MAX_TRANS (7)
    ) dut_i (
        .clk_i           (clk),
        .reset_i         (reset),
        .req_valid_0_i   (req_valid[0]), .req_ready_0_o (req_ready[0]),
        .req_addr_0_i    (req_addr[0]),  .req_write_0_i (req_write[0]),
        .req_wdata_0_i   (req_wdata[0]), .req_strb_0_i  (req_strb[0]),
        .rsp_valid_0_o   (rsp_valid[0]), .rsp_ready_0_i (rsp_ready[0]),
        .rsp_rdata_0_o   (rsp_rdata[0]), .rsp_err_0_o   (rsp_err[0]),
        .req_valid_1_i   (req_valid[1]), .req_ready_1_o (req_ready[1]),
        .req_addr_1_i    (req_addr[1]),  .req_write_1_i (req_write[1]),
        .req_wdata_1_i   (req_wdata[1]), .req_strb_1_i  (req_strb[1]),
        .rsp_valid_1_o   (rsp_valid[1]), .rsp_ready_1_i (rsp_ready[1]),
        .rsp_rdata_1_o   (rsp_rdata[1]), .rsp_err_1_o   (rsp_err[1]),
        .tgt_req_valid_o (tgt_req_valid),
        .tgt_req_ready_i (tgt_req_ready),
        .tgt_req_addr_o  (tgt_req_addr),
        .tgt_req_write_o (tgt_req_write),
        .tgt_req_wdata_o (tgt_req_wdata),
        .tgt_req_strb_o  (tgt_req_strb),
        .tgt_rsp_valid_i (tgt_rsp_valid),
        .tgt_rsp_ready_o (tgt_rsp_ready),
        .tgt_rsp_rdata_i (tgt_rsp_rdata),
        .tgt_rsp_err_i   (tgt_rsp_err),
        .pause_req_i     (pause_req),
        .pause_ack_o     (pause_ack),
        .addr_map_i      (addr_map)
    );

    for (genvar t = 0; t < 2; t++) begin : g_tgt
        tb_target_model u_mem (
            .clk_i       (clk),
            .reset_i     (reset),
            .delay_i     (tgt_delay[t]),
            .req_valid_i (tgt_req_valid[t]), .req_ready_o (tgt_req_ready[t]),
            .req_addr_i  (tgt_req_addr[t]),  .req_write_i (tgt_req_write[t]),
            .req_wdata_i (tgt_req_wdata[t]), .req_strb_i  (tgt_req_strb[t]),
            .rsp_valid_o (tgt_rsp_valid[t]), .rsp_ready_i (tgt_rsp_ready[t]),
            .rsp_rdata_o (tgt_rsp_rdata[t]), .rsp_err_o   (tgt_rsp_err[t]),
            .req_cnt_o   (tgt_req_cnt[t])
        );
    end

    function automatic data_t merge(input data_t old, input data_t d, input strb_t s);
        data_t r;
        r = old;
        for (int b = 0; b < STRB_WIDTH; b++) begin
            if (s[b]) begin
                r[8*b +: 8] = d[8*b +: 8];
            end
        end
        return r;
    endfunction

    function automatic data_t sb_read(input addr_t a);
        return sb.exists(a) ? sb[a] : '0;  // Memories start cleared
    endfunction

    task automatic check_data(input string name, input data_t got, input data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s got=%b exp=%b", $time, name, got, exp);
        end
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("FAILED t=%0t %s", $time, msg);
    endtask

    task automatic end_test(input string name, input int e0);
        tests++;
        $display("test %s: %0d errors", name, errors - e0);
    endtask

    task automatic drive_req(input int p, input addr_t a, input logic w, input data_t d,
                             input strb_t s);
        req_valid[p] = 1'b1;
        req_addr[p]  = a;
        req_write[p] = w;
        req_wdata[p] = d;
        req_strb[p]  = s;
    endtask

    // Handshake lands on the edge after ready is seen high
    task automatic wait_accept(input int p);
        @(negedge clk);
        while (!req_ready[p]) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        req_valid[p] = 1'b0;
    endtask

    task automatic send(input int p, input addr_t a, input logic w, input data_t d,
                        input strb_t s);
        @(posedge clk);
        #2;
        drive_req(p, a, w, d, s);
        wait_accept(p);
    endtask

    task automatic collect(input int p, output data_t rd, output logic re);
        @(negedge clk);
        while (!rsp_valid[p]) begin
            @(negedge clk);
        end
        rd = rsp_rdata[p];
        re = rsp_err[p];
        @(posedge clk);
    endtask

    task automatic transact(input int p, input addr_t a, input logic w, input data_t d,
                            input strb_t s, output data_t rd, output logic re);
        send(p, a, w, d, s);
        collect(p, rd, re);
    endtask

    task automatic write_word(input int p, input addr_t a, input data_t d, input strb_t s);
        data_t rd;
        logic  re;
        transact(p, a, 1'b1, d, s, rd, re);
        check_err($sformatf("rsp_err_%0d_o", p), re, 1'b0);
        sb[a] = merge(sb_read(a), d, s);
    endtask

    task automatic read_word(input int p, input addr_t a);
        data_t rd;
        logic  re;
        transact(p, a, 1'b0, '0, '0, rd, re);
        check_err($sformatf("rsp_err_%0d_o", p), re, 1'b0);
        check_data($sformatf("rsp_rdata_%0d_o", p), rd, sb_read(a));
    endtask

    task automatic test_write_read();
        int    e0;
        addr_t a;
        e0 = errors;
        for (int p = 0; p < 2; p++) begin
            for (int t = 0; t < 2; t++) begin
                a = addr_t'(32'h100 + t * 32'h1000 + p * 32'h10);
                write_word(p, a, data_t'($random(seed)), 4'hf);
                write_word(p, a, data_t'($random(seed)), 4'($random(seed)));
                read_word(p, a);
            end
        end
        end_test("write_read", e0);
    endtask

    task automatic test_unmapped();
        int          e0;
        logic [31:0] c0, c1;
        data_t       rd;
        logic        re;
        e0 = errors;
        @(negedge clk);
        c0 = tgt_req_cnt[0];
        c1 = tgt_req_cnt[1];
        transact(0, 32'h0000_3000, 1'b0, '0, '0, rd, re);
        check_err("rsp_err_0_o", re, 1'b1);
        check_data("rsp_rdata_0_o", rd, '0);
        transact(1, 32'h8000_0010, 1'b1, data_t'($random(seed)), 4'hf, rd, re);
        check_err("rsp_err_1_o", re, 1'b1);
        check_data("rsp_rdata_1_o", rd, '0);
        @(negedge clk);
        if (tgt_req_cnt[0] != c0 || tgt_req_cnt[1] != c1) begin
            note_failure("a target model received a request for an unmapped address");
        end
        end_test("unmapped", e0);
    endtask

    task automatic burst(input int p, input int r);
        addr_t a;
        for (int k = 0; k < 2; k++) begin
            a = addr_t'(32'h400 + p * 32'h40 + r * 32'h10 + k * 4);
            write_word(p, a, data_t'($random(seed)), 4'hf);
            read_word(p, a);
        end
    endtask

    task automatic test_contention();
        int e0;
        e0 = errors;
        for (int r = 0; r < 2; r++) begin
            @(posedge clk);
            #2;
            tgt_delay[0] = 4'($random(seed));
            tgt_delay[1] = 4'($random(seed));
            fork
                burst(0, r);
                burst(1, r);
            join
        end
        end_test("contention", e0);
    endtask

    task automatic test_backpressure();
        int    e0;
        data_t rd;
        logic  re;
        e0 = errors;
        @(posedge clk);
        #2;
        rsp_ready[0] = 1'b0;
        send(0, 32'h0000_0100, 1'b0, '0, '0);
        @(negedge clk);
        while (!rsp_valid[0]) begin
            @(negedge clk);
        end
        write_word(1, 32'h0000_1200, data_t'($random(seed)), 4'hf);
        read_word(1, 32'h0000_1200);
        @(negedge clk);
        if (!rsp_valid[0]) begin
            note_failure("initiator 0 response vanished while rsp_ready was low");
        end
        check_data("rsp_rdata_0_o", rsp_rdata[0], sb_read(32'h0000_0100));
        @(posedge clk);
        #2;
        rsp_ready[0] = 1'b1;
        collect(0, rd, re);
        check_err("rsp_err_0_o", re, 1'b0);
        check_data("rsp_rdata_0_o", rd, sb_read(32'h0000_0100));
        end_test("backpressure", e0);
    endtask

    task automatic test_pause();
        int    e0;
        int    n;
        data_t rd;
        logic  re;
        e0 = errors;
        @(posedge clk);
        #2;
        tgt_delay[0] = 4'd8;  // Keep the read pending for a while
        send(0, 32'h0000_0100, 1'b0, '0, '0);
        pause_req = 1'b1;
        @(negedge clk);
        while (!rsp_valid[0]) begin
            if (pause_ack) begin
                note_failure("pause_ack_o rose before the pending response was delivered");
            end
            @(negedge clk);
        end
        if (pause_ack) begin
            note_failure("pause_ack_o high while a response waits for delivery");
        end
        rd = rsp_rdata[0];
        re = rsp_err[0];
        check_err("rsp_err_0_o", re, 1'b0);
        check_data("rsp_rdata_0_o", rd, sb_read(32'h0000_0100));
        n = 0;
        @(negedge clk);
        while (!pause_ack && n < 10) begin
            n++;
            @(negedge clk);
        end
        if (!pause_ack) begin
            note_failure("pause_ack_o never rose after the port drained");
        end
        @(posedge clk);
        #2;
        drive_req(1, 32'h0000_1200, 1'b0, '0, '0);
        repeat (4) begin
            @(negedge clk);
            if (req_ready[1]) begin
                note_failure("initiator 1 request accepted during pause");
            end
            if (!pause_ack) begin
                note_failure("pause_ack_o dropped while the pause was held");
            end
        end
        @(posedge clk);
        #2;
        pause_req = 1'b0;
        wait_accept(1);
        collect(1, rd, re);
        check_err("rsp_err_1_o", re, 1'b0);
        check_data("rsp_rdata_1_o", rd, sb_read(32'h0000_1200));
        end_test("pause", e0);
    endtask

    initial begin
        repeat (TEST_LEN * 200) @(posedge clk);
        $display("TIMEOUT after %0d cycles, a transaction never completed", TEST_LEN * 200);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        seed      = 32'hb12e;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        clk       = 1'b0;
        reset     = 1'b1;
        pause_req = 1'b0;
        req_valid = '0;
        req_write = '0;
        rsp_ready = 2'b11;
        tgt_delay = '0;
        for (int p = 0; p < 2; p++) begin
            req_addr[p]  = '0;
            req_wdata[p] = '0;
            req_strb[p]  = '0;
        end
        addr_map[0] = '{start_addr: 32'h0000_0000, end_addr: 32'h0000_1000};
        addr_map[1] = '{start_addr: 32'h0000_1000, end_addr: 32'h0000_2000};
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;

        test_write_read();
        test_unmapped();
        test_contention();
        test_backpressure();
        test_pause();

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
common/xbar_pkg.sv
logic/axil_pause.sv
xbar/addr_decode.sv
xbar/xbar_router.sv
xbar/axil_xbar.sv
dv/tb_target_model.sv
dv/tb_axil_xbar.sv

/* Makefile */
TOP := tb_axil_xbar

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 -f src.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir
